//--- tb.f
+incdir+hw
+incdir+verification
hw/aluPkg.sv
hw/cmdPkg.sv
hw/regFile.sv
hw/alu.sv
hw/execCtrl.sv
hw/aluCore.sv
verification/aluCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= aluCoreTb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/aluModel.svh
////////////////////////////////////////
// Reference model of the execution subsystem
// register array, PSW, operation rules and LFSR
////////////////////////////////////////
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

word_t       modelRegs [`REG_CNT];
psw_t        modelPsw;
logic [31:0] lfsrState = 32'hf5dc550b;

// taps 32, 22, 2, 1
function automatic logic [31:0] lfsrStep(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] randBits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsrState = lfsrStep(lfsrState);
		v = {v[30:0], lfsrState[0]};	// one step per bit
	end
	return v;
endfunction

function automatic aluResult_t modelOp(input aluOp_t op, input logic byteMode,
		input word_t d, input word_t s, input psw_t pin);
	int          w;
	int          idx;
	logic [16:0] wide;
	logic [15:0] b;
	logic [15:0] r;
	logic [15:0] m;
	logic [15:0] bitMask;
	logic [4:0]  dig;
	logic        cy;
	aluResult_t  res;
	w = byteMode ? 8 : 16;
	m = byteMode ? 16'h00ff : 16'hffff;
	res = '0;
	res.flags.c = pin.c;	// kept unless the op says otherwise
	res.flags.v = pin.v;
	res.wrEn = !(op == CMP || op == BIT);
	idx = (int'(s) > w - 1) ? w - 1 : int'(s);
	bitMask = 16'h1 << idx;
	r = d;
	case (op)
		ADD, ADDC, SUB, SUBC, CMP: begin
			b = (op == SUB || op == SUBC || op == CMP) ? ~s : s;
			cy = (op == SUB || op == CMP) ? 1'b1 : ((op == ADDC || op == SUBC) ? pin.c : 1'b0);
			wide = {1'b0, d & m} + {1'b0, b & m} + 17'(cy);
			r = wide[15:0];
			res.flags.c = wide[w];	// carry out of the width
			res.flags.v = (d[w-1] == b[w-1]) && (r[w-1] != d[w-1]);
		end
		DADD: begin
			cy = pin.c;
			for (int i = 0; i < w / 4; i++) begin
				dig = {1'b0, d[4*i +: 4]} + {1'b0, s[4*i +: 4]} + 5'(cy);
				cy = (dig > 5'd9);
				if (cy)
					dig = dig - 5'd10;
				r[4*i +: 4] = dig[3:0];
			end
			res.flags.c = cy;	// decimal carry
		end
		XOR: r = d ^ s;
		AND: r = d & s;
		OR:  r = d | s;
		BIT: r = d & bitMask;
		BIC: r = d & ~bitMask;
		BIS: r = d | bitMask;
		SRA: begin
			r = (d & m) >> 1;
			r[w-1] = d[w-1];
			res.flags.c = d[0];
			res.flags.v = 1'b0;
		end
		RRC: begin
			r = (d & m) >> 1;
			r[w-1] = pin.c;	// old carry rotates in
			res.flags.c = d[0];
		end
		default: r = d;
	endcase
	if (byteMode)
		r = {d[15:8], r[7:0]};
	res.flags.n = r[w-1];
	res.flags.z = ((r & m) == 16'h0000);
	res.value = r;
	return res;
endfunction

`endif

//--- verification/aluCoreTb.sv
////////////////////////////////////////
// Testbench for the execution subsystem
// random commands over req/ack checked against a model
////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_consts.svh"

module aluCoreTb;
	import aluPkg::*;
	import cmdPkg::*;

	`include "aluModel.svh"

	localparam int loadCount = 8;
	localparam int randCount = 400;
	localparam int cyclesPerCmd = 40;
	localparam int clkPeriod = 10;
	localparam int timeoutNs = (loadCount + randCount) * cyclesPerCmd * clkPeriod;
	localparam int ackLimit = 20;	// cycles to wait for ack

	logic  E = 1'b0;
	logic  rst_i;
	logic  req_i;
	cmd_t  cmd_i;
	logic  ack_o;
	word_t result_o;
	psw_t  psw_o;

	int errCount;
	int cmdCount;

	aluCore i_aluCore (
		.E(E), .rst_i(rst_i), .req_i(req_i), .cmd_i(cmd_i),
		.ack_o(ack_o), .result_o(result_o), .psw_o(psw_o)
	);

	always #(clkPeriod / 2) E = ~E;

	function automatic cmd_t randomCmd();
		cmd_t        c;
		logic [31:0] r;
		r = randBits(3);
		c.kind = (r == 0) ? LOAD : EXEC;	// about one in eight
		r = randBits(4) % 14;
		c.op = aluOp_t'(r[3:0]);
		r = randBits(1);
		c.byteMode = r[0];
		r = randBits(2);
		c.updatePsw = (r != 0);
		r = randBits(2);
		c.srcIsImm = (r == 0);
		r = randBits(3);
		c.dst = r[2:0];
		r = randBits(3);
		c.src = r[2:0];
		// small bit indices land on both sides of the clamp
		r = (c.op inside {BIT, BIC, BIS}) ? randBits(5) : randBits(16);
		c.imm = r[15:0];
		return c;
	endfunction

	task automatic modelCmd(input cmd_t c, output word_t expRes, output psw_t expPsw);
		aluResult_t r;
		word_t      srcVal;
		if (c.kind == LOAD) begin
			modelRegs[c.dst] = c.imm;
			expRes = c.imm;
		end else begin
			srcVal = c.srcIsImm ? c.imm : modelRegs[c.src];
			r = modelOp(c.op, c.byteMode, modelRegs[c.dst], srcVal, modelPsw);
			if (r.wrEn)
				modelRegs[c.dst] = r.value;
			if (c.updatePsw)
				modelPsw = r.flags;
			expRes = r.value;
		end
		expPsw = modelPsw;
	endtask

	// one full four-phase handshake started 1 ns after a rising edge
	task automatic sendCmd(input cmd_t c);
		word_t expRes;
		psw_t  expPsw;
		int    waited;
		int    hold;
		int    gap;
		cmd_i = c;
		req_i = 1'b1;
		waited = 0;
		do begin
			@(posedge E);
			#1;
			waited++;
		end while (!ack_o && waited < ackLimit);
		assert (ack_o) else begin
			errCount++;
			$display("ack_o never rose for command %0d within %0d cycles", cmdCount, ackLimit);
			req_i = 1'b0;
			return;
		end
		assert (waited == 4) else begin	// sampling edge plus three
			errCount++;
			$display("Error at %0t: ack_o latency = %0d, expected 3", $time, waited - 1);
		end
		modelCmd(c, expRes, expPsw);
		assert (result_o == expRes) else begin
			errCount++;
			$display("Error at %0t: result_o = %h, expected %h", $time, result_o, expRes);
		end
		assert (psw_o == expPsw) else begin
			errCount++;
			$display("Error at %0t: psw_o = %h, expected %h", $time, psw_o, expPsw);
		end
		hold = int'(randBits(2));
		for (int i = 0; i < hold; i++) begin
			@(posedge E);
			#1;
			assert (ack_o) else begin
				errCount++;
				$display("Error at %0t: ack_o = %b, expected 1", $time, ack_o);
			end
		end
		req_i = 1'b0;
		@(posedge E);
		#1;
		assert (!ack_o) else begin	// one edge after req falls
			errCount++;
			$display("Error at %0t: ack_o = %b, expected 0", $time, ack_o);
		end
		gap = int'(randBits(2));
		for (int i = 0; i < gap; i++) begin
			@(posedge E);
			#1;
		end
		cmdCount++;
	endtask

	initial begin : mainSeq
		cmd_t c;
		errCount = 0;
		cmdCount = 0;
		rst_i = 1'b1;
		req_i = 1'b0;
		cmd_i = '0;
		for (int i = 0; i < `REG_CNT; i++)
			modelRegs[i] = '0;
		modelPsw = '0;
		repeat (8) @(posedge E);
		#1;
		rst_i = 1'b0;
		assert (!ack_o) else begin
			errCount++;
			$display("Error at %0t: ack_o = %b, expected 0", $time, ack_o);
		end
		for (int i = 0; i < loadCount; i++) begin
			c = randomCmd();
			c.kind = LOAD;	// fill every register once
			c.dst = regIdx_t'(i);
			sendCmd(c);
		end
		repeat (randCount) sendCmd(randomCmd());
		$display("Checked %0d commands, %0d errors", cmdCount, errCount);
		if (errCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin : watchdog
		#(timeoutNs);
		$display("Watchdog expired at %0t with %0d of %0d commands done, DUT hung",
			$time, cmdCount, loadCount + randCount);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- hw/aluCore.sv
////////////////////////////////////////
// Execution subsystem top
// controller, register file and ALU
////////////////////////////////////////
`timescale 1ns/1ps

module aluCore (
	input  logic          E,
	input  logic          rst_i,
	input  logic          req_i,
	input  cmdPkg::cmd_t  cmd_i,
	output logic          ack_o,
	output aluPkg::word_t result_o,
	output aluPkg::psw_t  psw_o
);
	import aluPkg::*;
	import cmdPkg::*;

	regIdx_t    rdAddrA, rdAddrB, wrAddr;
	word_t      rdDataA, rdDataB, wrData;
	word_t      aluDst, aluSrc;
	logic       aluGo, aluByte, wrEn;
	aluOp_t     aluOp;
	psw_t       aluPsw;
	aluResult_t aluRes;

	execCtrl i_execCtrl (
		.E(E), .rst_i(rst_i),
		.req_i(req_i), .cmd_i(cmd_i),
		.ack_o(ack_o), .result_o(result_o), .psw_o(psw_o),
		.rdAddrA_o(rdAddrA), .rdAddrB_o(rdAddrB),
		.rdDataA_i(rdDataA), .rdDataB_i(rdDataB),
		.aluGo_o(aluGo), .aluOp_o(aluOp), .aluByte_o(aluByte),
		.aluDst_o(aluDst), .aluSrc_o(aluSrc), .aluPsw_o(aluPsw),
		.aluRes_i(aluRes),
		.wrEn_o(wrEn), .wrAddr_o(wrAddr), .wrData_o(wrData)
	);

	regFile i_regFile (
		.E(E), .rst_i(rst_i),
		.rdAddrA_i(rdAddrA), .rdAddrB_i(rdAddrB),
		.rdDataA_o(rdDataA), .rdDataB_o(rdDataB),
		.wrEn_i(wrEn), .wrAddr_i(wrAddr), .wrData_i(wrData)
	);

	alu i_alu (
		.E(E), .rst_i(rst_i),
		.go_i(aluGo), .op_i(aluOp), .byteMode_i(aluByte),
		.dst_i(aluDst), .src_i(aluSrc), .pswIn_i(aluPsw),
		.res_o(aluRes)
	);

endmodule

//--- hw/execCtrl.sv
////////////////////////////////////////
// Execute controller
// req/ack handshake, operand fetch, write back, PSW
////////////////////////////////////////
`timescale 1ns/1ps

module execCtrl (
	input  logic               E,
	input  logic               rst_i,
	input  logic               req_i,
	input  cmdPkg::cmd_t       cmd_i,
	output logic               ack_o,
	output aluPkg::word_t      result_o,
	output aluPkg::psw_t       psw_o,
	output cmdPkg::regIdx_t    rdAddrA_o,
	output cmdPkg::regIdx_t    rdAddrB_o,
	input  aluPkg::word_t      rdDataA_i,
	input  aluPkg::word_t      rdDataB_i,
	output logic               aluGo_o,
	output aluPkg::aluOp_t     aluOp_o,
	output logic               aluByte_o,
	output aluPkg::word_t      aluDst_o,
	output aluPkg::word_t      aluSrc_o,
	output aluPkg::psw_t       aluPsw_o,
	input  aluPkg::aluResult_t aluRes_i,
	output logic               wrEn_o,
	output cmdPkg::regIdx_t    wrAddr_o,
	output aluPkg::word_t      wrData_o
);
	import aluPkg::*;
	import cmdPkg::*;

	typedef enum logic [2:0] {ST_IDLE, ST_EXEC, ST_WB, ST_ACK, ST_RELEASE} state_t;

	state_t state;
	cmd_t   cmdReg;
	word_t  dstReg;
	word_t  srcReg;
	word_t  resReg;
	psw_t   pswReg;

	// cmd_i is stable while req_i is high
	assign rdAddrA_o = cmd_i.dst;
	assign rdAddrB_o = cmd_i.src;

	always_ff @(posedge E) begin
		if (rst_i) begin
			state <= ST_IDLE;
			ack_o <= 1'b0;
			aluGo_o <= 1'b0;
			wrEn_o <= 1'b0;
			pswReg <= '0;
		end else begin
			case (state)
				ST_IDLE: if (req_i) begin
					aluGo_o <= 1'b1;
					state <= ST_EXEC;
				end
				ST_EXEC: begin
					aluGo_o <= 1'b0;	// alu captures on this edge
					state <= ST_WB;
				end
				ST_WB: begin
					wrEn_o <= (cmdReg.kind == LOAD) || aluRes_i.wrEn;
					if (cmdReg.kind == EXEC && cmdReg.updatePsw)
						pswReg <= aluRes_i.flags;
					state <= ST_ACK;
				end
				ST_ACK: begin
					wrEn_o <= 1'b0;
					ack_o <= 1'b1;	// third edge after req sampled
					state <= ST_RELEASE;
				end
				default: if (!req_i) begin	// master holds req to stall
					ack_o <= 1'b0;
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge E) begin
		if (state == ST_IDLE && req_i) begin
			cmdReg <= cmd_i;
			dstReg <= rdDataA_i;
			srcReg <= cmd_i.srcIsImm ? cmd_i.imm : rdDataB_i;
		end
		if (state == ST_WB)
			resReg <= (cmdReg.kind == LOAD) ? cmdReg.imm : aluRes_i.value;
	end

	assign aluOp_o   = cmdReg.op;
	assign aluByte_o = cmdReg.byteMode;
	assign aluDst_o  = dstReg;
	assign aluSrc_o  = srcReg;
	assign aluPsw_o  = pswReg;	// carry in for addc, subc, dadd, rrc
	assign wrAddr_o  = cmdReg.dst;
	assign wrData_o  = resReg;
	assign result_o  = resReg;
	assign psw_o     = pswReg;

endmodule

//--- hw/alu.sv
////////////////////////////////////////
// ALU
// word or byte result and flags, registered on go
////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu (
	input  logic               E,
	input  logic               rst_i,
	input  logic               go_i,
	input  aluPkg::aluOp_t     op_i,
	input  logic               byteMode_i,
	input  aluPkg::word_t      dst_i,
	input  aluPkg::word_t      src_i,
	input  aluPkg::psw_t       pswIn_i,
	output aluPkg::aluResult_t res_o
);
	import aluPkg::*;

	logic        isSub;
	word_t       addB;
	logic        addCin;
	logic [16:0] sumW;
	logic [8:0]  sumB;
	word_t       sum;
	logic        addC;
	logic        addV;
	word_t       bcd;
	logic        bcdC;
	logic [3:0]  bitIdx;
	word_t       mask;
	word_t       raw;
	word_t       value;
	logic        cOut;
	logic        vOut;
	logic        nOut;
	logic        zOut;
	word_t       flagVec;
	aluResult_t  nextRes;

	// subtraction is dst + ~src + cin
	always_comb begin
		isSub = (op_i == SUB) || (op_i == SUBC) || (op_i == CMP);
		addB = isSub ? ~src_i : src_i;
		case (op_i)
			ADDC, SUBC: addCin = pswIn_i.c;
			SUB, CMP:   addCin = 1'b1;
			default:    addCin = 1'b0;
		endcase
	end

	assign sumW = {1'b0, dst_i} + {1'b0, addB} + 17'(addCin);
	assign sumB = {1'b0, dst_i[7:0]} + {1'b0, addB[7:0]} + 9'(addCin);
	assign sum  = sumW[15:0];
	assign addC = byteMode_i ? sumB[8] : sumW[16];	// no borrow on sub

	// set when same input signs give a flipped result sign
	assign addV = byteMode_i ? ((dst_i[7] == addB[7]) && (sumB[7] != dst_i[7]))
	                         : ((dst_i[15] == addB[15]) && (sumW[15] != dst_i[15]));

	always_comb begin : bcdAdd
		logic [4:0] digit;
		logic       carry;
		carry = pswIn_i.c;
		bcdC = 1'b0;
		bcd = '0;
		for (int i = 0; i < 4; i++) begin
			digit = {1'b0, dst_i[4*i +: 4]} + {1'b0, src_i[4*i +: 4]} + 5'(carry);
			carry = (digit > 5'd9);
			if (carry)
				digit = digit + 5'd6;	// skip the six unused codes
			bcd[4*i +: 4] = digit[3:0];
			if (i == (byteMode_i ? 1 : 3))
				bcdC = carry;	// decimal carry of top digit
		end
	end

	// bit index saturates at the top bit of the width
	assign bitIdx = byteMode_i ? ((src_i > 16'd7) ? 4'd7 : src_i[3:0])
	                           : ((src_i > 16'd15) ? 4'd15 : src_i[3:0]);
	assign mask = word_t'(1) << bitIdx;

	always_comb begin
		raw = '0;
		cOut = pswIn_i.c;	// logic ops keep c and v
		vOut = pswIn_i.v;
		case (op_i)
			ADD, ADDC, SUB, SUBC, CMP: begin
				raw = sum;
				cOut = addC;
				vOut = addV;
			end
			DADD: begin
				raw = bcd;
				cOut = bcdC;
			end
			XOR: raw = dst_i ^ src_i;
			AND: raw = dst_i & src_i;
			OR:  raw = dst_i | src_i;
			BIT: raw = dst_i & mask;
			BIC: raw = dst_i & ~mask;
			BIS: raw = dst_i | mask;
			SRA: begin
				raw = byteMode_i ? {8'h00, dst_i[7], dst_i[7:1]} : {dst_i[15], dst_i[15:1]};
				cOut = dst_i[0];
				vOut = 1'b0;
			end
			RRC: begin
				raw = byteMode_i ? {8'h00, pswIn_i.c, dst_i[7:1]} : {pswIn_i.c, dst_i[15:1]};
				cOut = dst_i[0];
			end
			default: raw = dst_i;
		endcase

		// byte ops keep the dst high byte
		value = byteMode_i ? {dst_i[15:8], raw[7:0]} : raw;
		nOut = byteMode_i ? value[7] : value[15];
		zOut = byteMode_i ? (value[7:0] == 8'h00) : (value == '0);

		flagVec = '0;
		flagVec[`PSW_C] = cOut;
		flagVec[`PSW_Z] = zOut;
		flagVec[`PSW_N] = nOut;
		flagVec[`PSW_V] = vOut;

		nextRes.value = value;
		nextRes.flags = psw_t'(flagVec);
		nextRes.wrEn = !(op_i inside {CMP, BIT});	// flags only
	end

	always_ff @(posedge E) begin
		if (rst_i)
			res_o <= '0;
		else if (go_i)
			res_o <= nextRes;	// held until next go
	end

endmodule

//--- hw/regFile.sv
////////////////////////////////////////
// Register file
// two async read ports, one sync write port
////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_consts.svh"

module regFile (
	input  logic            E,
	input  logic            rst_i,
	input  cmdPkg::regIdx_t rdAddrA_i,
	input  cmdPkg::regIdx_t rdAddrB_i,
	output aluPkg::word_t   rdDataA_o,
	output aluPkg::word_t   rdDataB_o,
	input  logic            wrEn_i,
	input  cmdPkg::regIdx_t wrAddr_i,
	input  aluPkg::word_t   wrData_i
);
	import aluPkg::*;

	word_t regs [`REG_CNT];

	// old value is seen in the write cycle
	assign rdDataA_o = regs[rdAddrA_i];
	assign rdDataB_o = regs[rdAddrB_i];

	always_ff @(posedge E) begin
		if (rst_i) begin
			for (int i = 0; i < `REG_CNT; i++)
				regs[i] <= '0;
		end else if (wrEn_i) begin
			regs[wrAddr_i] <= wrData_i;
		end
	end

endmodule

//--- hw/cmdPkg.sv
////////////////////////////////////////
// Command port types
////////////////////////////////////////
`include "alu_consts.svh"

package cmdPkg;

	typedef logic [`REG_IDX_W-1:0] regIdx_t;

	// load fills a register with imm
	typedef enum logic {
		EXEC,
		LOAD
	} cmdKind_t;

	typedef struct packed {
		cmdKind_t       kind;
		aluPkg::aluOp_t op;
		logic           byteMode;	// .b form
		logic           updatePsw;
		logic           srcIsImm;	// imm replaces src register
		regIdx_t        dst;
		regIdx_t        src;
		aluPkg::word_t  imm;
	} cmd_t;

endpackage

//--- hw/aluPkg.sv
////////////////////////////////////////
// ALU types
// data word, opcodes, status word and ALU result
////////////////////////////////////////
`include "alu_consts.svh"

package aluPkg;

	typedef logic [`WORD_W-1:0] word_t;

	// two-operand operations, width chosen separately
	typedef enum logic [3:0] {
		ADD,
		ADDC,
		SUB,
		SUBC,
		DADD,	// bcd add with carry
		CMP,
		XOR,
		AND,
		OR,
		BIT,
		BIC,
		BIS,
		SRA,
		RRC
	} aluOp_t;

	// layout follows the PSW_* bit positions
	typedef struct packed {
		logic [10:0] reserved;
		logic        v;
		logic        spare;	// S bit, kept zero
		logic        n;
		logic        z;
		logic        c;
	} psw_t;

	typedef struct packed {
		word_t value;
		psw_t  flags;
		logic  wrEn;	// low for cmp and bit
	} aluResult_t;

endpackage

//--- hw/alu_consts.svh
////////////////////////////////////////
// ALU subsystem constants
// data width, register file depth and PSW flag positions
////////////////////////////////////////
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// datapath
`define WORD_W 16
// 0..7 general registers
`define REG_CNT 8
`define REG_IDX_W 3

// status word bit positions without the S bit
`define PSW_C 0
`define PSW_Z 1
`define PSW_N 2
`define PSW_V 4

`endif
